/* hw/avl_bus_pkg.sv */
package avl_bus_pkg;

  //////////////////////////////////////////////////////////////////////
  // bus widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] addr_t;  // byte address
  typedef logic [31:0] data_t;
  typedef logic [3:0]  be_t;

  //////////////////////////////////////////////////////////////////////
  // request and response bundles
  //////////////////////////////////////////////////////////////////////

  // master request, also used for the slave strobe
  typedef struct packed {
    logic  read;
    logic  write;
    addr_t addr;
    data_t wdata;
    be_t   byteenable;
  } avl_req_t;

  // reply seen by a master, ack is a one cycle pulse
  typedef struct packed {
    logic  ack;
    logic  err;
    data_t rdata;
  } avl_mrsp_t;

  typedef struct packed {
    logic  done;   // one cycle, no back-pressure
    data_t rdata;
  } avl_srsp_t;

  // transaction sequencer states
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT,
    RESP
  } arb_state_t;

endpackage

/* hw/avl_bus_arbiter.sv */
module avl_bus_arbiter #(
  parameter int MASTER_NUM = 3
) (
  input  logic                            clk,
  input  logic                            arst_n,
  input  logic [MASTER_NUM-1:0]           req_pending,
  input  logic                            unmapped,
  input  logic                            slave_done,
  input  logic                            expire,
  output avl_bus_pkg::arb_state_t         state,
  output logic [$clog2(MASTER_NUM)-1:0]   grant
);

  import avl_bus_pkg::*;

  localparam int GW = $clog2(MASTER_NUM);

  arb_state_t    state_nxt;
  logic [GW-1:0] ptr;       // first master to look at
  logic [GW-1:0] grant_q;
  logic [GW-1:0] winner;

  //////////////////////////////////////////////////////////////////////
  // round-robin search
  //////////////////////////////////////////////////////////////////////

  // walk from the highest offset down so the nearest requester wins
  always_comb begin
    int idx;
    winner = ptr;
    for (int off = MASTER_NUM - 1; off >= 0; off--) begin
      idx = (int'(ptr) + off) % MASTER_NUM;
      if (req_pending[idx]) begin
        winner = GW'(idx);
      end
    end
  end

  // winner is live while idle so the datapath can capture at the same edge
  assign grant = (state == IDLE) ? winner : grant_q;

  //////////////////////////////////////////////////////////////////////
  // transaction sequence
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (|req_pending) begin
          state_nxt = ISSUE;
        end
      end
      ISSUE: begin
        state_nxt = unmapped ? RESP : WAIT;  // no slave, no wait
      end
      WAIT: begin
        if (slave_done || expire) begin
          state_nxt = RESP;
        end
      end
      default: begin
        state_nxt = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= IDLE;
      grant_q <= '0;
      ptr     <= '0;
    end else begin
      state <= state_nxt;
      if (state == IDLE && (|req_pending)) begin
        grant_q <= winner;
      end
      if (state == RESP) begin
        // next search starts one past the served master
        ptr <= (grant_q == GW'(MASTER_NUM - 1)) ? '0 : grant_q + 1'b1;
      end
    end
  end

endmodule

/* hw/avl_bus_timeout.sv */
module avl_bus_timeout #(
  parameter int TIMEOUT_CYCLES = 16
) (
  input  logic                    clk,
  input  logic                    arst_n,
  input  avl_bus_pkg::arb_state_t state,
  output logic                    expire
);

  import avl_bus_pkg::*;

  localparam int CW = $clog2(TIMEOUT_CYCLES + 1);

  logic [CW-1:0] cnt;

  // strobe goes out in ISSUE, so the first WAIT cycle is cycle one
  // and cnt hits zero on cycle TIMEOUT_CYCLES
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else begin
      case (state)
        ISSUE: begin
          cnt <= CW'(TIMEOUT_CYCLES - 1);
        end
        WAIT: begin
          if (cnt != '0) begin
            cnt <= cnt - 1'b1;
          end
        end
        default: begin
          cnt <= '0;  // parked outside a transaction
        end
      endcase
    end
  end

  assign expire = (state == WAIT) && (cnt == '0);

endmodule

/* hw/avl_bus_addr_decode.sv */
module avl_bus_addr_decode #(
  parameter int                 SLAVE_NUM = 4,
  parameter avl_bus_pkg::addr_t MAP_BASE [SLAVE_NUM] = '{
    32'h0000_0000,
    32'h0001_0000,
    32'h8000_0000,
    32'h8001_0000
  },
  parameter int                 MAP_FIELD_LEN [SLAVE_NUM] = '{16, 16, 16, 16}
) (
  input  avl_bus_pkg::addr_t               addr,
  output logic [$clog2(SLAVE_NUM+1)-1:0]   slave_sel,  // SLAVE_NUM means none
  output logic                             unmapped
);

  import avl_bus_pkg::*;

  localparam int SW = $clog2(SLAVE_NUM + 1);

  // upper len bits set, len of zero matches everything
  function automatic addr_t field_mask(int len);
    addr_t ones;
    ones = '1;
    if (len <= 0) begin
      return '0;
    end
    return ones << (32 - len);
  endfunction

  //////////////////////////////////////////////////////////////////////
  // map compare
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    addr_t mask;
    slave_sel = SW'(SLAVE_NUM);
    unmapped  = 1'b1;
    // scan high to low so the lowest claiming slave is left
    for (int j = SLAVE_NUM - 1; j >= 0; j--) begin
      mask = field_mask(MAP_FIELD_LEN[j]);
      if ((addr & mask) == (MAP_BASE[j] & mask)) begin
        slave_sel = SW'(j);
        unmapped  = 1'b0;
      end
    end
  end

endmodule

/* hw/avl_bus_datapath.sv */
module avl_bus_datapath #(
  parameter int MASTER_NUM = 3,
  parameter int SLAVE_NUM  = 4
) (
  input  logic                              clk,
  input  logic                              arst_n,
  input  avl_bus_pkg::avl_req_t             m_req [MASTER_NUM],
  output avl_bus_pkg::avl_mrsp_t            m_rsp [MASTER_NUM],
  output avl_bus_pkg::avl_req_t             s_req [SLAVE_NUM],
  input  avl_bus_pkg::avl_srsp_t            s_rsp [SLAVE_NUM],
  input  avl_bus_pkg::arb_state_t           state,
  input  logic [$clog2(MASTER_NUM)-1:0]     grant,
  input  logic [$clog2(SLAVE_NUM+1)-1:0]    slave_sel,
  output avl_bus_pkg::addr_t                cur_addr,
  output logic                              slave_done
);

  import avl_bus_pkg::*;

  localparam int GW = $clog2(MASTER_NUM);
  localparam int SW = $clog2(SLAVE_NUM + 1);

  avl_req_t req_q;      // captured master request
  data_t    rdata_q;
  logic     err_q;
  logic     sel_done;
  data_t    sel_rdata;

  //////////////////////////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////////////////////////

  // last load happens at the edge that leaves IDLE
  always_ff @(posedge clk) begin
    if (state == IDLE) begin
      req_q <= m_req[grant];
    end
  end

  assign cur_addr = req_q.addr;

  always_comb begin
    for (int j = 0; j < SLAVE_NUM; j++) begin
      s_req[j] = '0;
      if (state == ISSUE && slave_sel == SW'(j)) begin
        s_req[j] = req_q;  // single-cycle strobe
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // response side
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    sel_done  = 1'b0;
    sel_rdata = '0;
    for (int j = 0; j < SLAVE_NUM; j++) begin
      if (slave_sel == SW'(j)) begin
        sel_done  = s_rsp[j].done;
        sel_rdata = s_rsp[j].rdata;
      end
    end
  end

  assign slave_done = (state == WAIT) && sel_done;  // late replies fall outside WAIT

  // err assumed until the slave answers; unmapped and timeout never clear it
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_q <= 1'b0;
    end else if (state == ISSUE) begin
      err_q <= 1'b1;
    end else if (slave_done) begin
      err_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (state == ISSUE) begin
      rdata_q <= '0;
    end else if (slave_done && req_q.read) begin
      rdata_q <= sel_rdata;
    end
  end

  always_comb begin
    for (int i = 0; i < MASTER_NUM; i++) begin
      m_rsp[i] = '0;
      if (state == RESP && grant == GW'(i)) begin
        m_rsp[i].ack   = 1'b1;
        m_rsp[i].err   = err_q;
        m_rsp[i].rdata = rdata_q;
      end
    end
  end

endmodule

/* hw/avl_bus_n2n.sv */
module avl_bus_n2n #(
  parameter int                 MASTER_NUM     = 3,
  parameter int                 SLAVE_NUM      = 4,
  parameter int                 TIMEOUT_CYCLES = 16,
  parameter avl_bus_pkg::addr_t MAP_BASE [SLAVE_NUM] = '{
    32'h0000_0000,
    32'h0001_0000,
    32'h8000_0000,
    32'h8001_0000
  },
  parameter int                 MAP_FIELD_LEN [SLAVE_NUM] = '{16, 16, 16, 16}
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  avl_bus_pkg::avl_req_t  m_req [MASTER_NUM],
  output avl_bus_pkg::avl_mrsp_t m_rsp [MASTER_NUM],
  output avl_bus_pkg::avl_req_t  s_req [SLAVE_NUM],
  input  avl_bus_pkg::avl_srsp_t s_rsp [SLAVE_NUM]
);

  import avl_bus_pkg::*;

  logic [MASTER_NUM-1:0]          req_pending;
  arb_state_t                     state;
  logic [$clog2(MASTER_NUM)-1:0]  grant;
  logic [$clog2(SLAVE_NUM+1)-1:0] slave_sel;
  logic                           unmapped;
  logic                           slave_done;
  logic                           expire;
  addr_t                          cur_addr;

  for (genvar i = 0; i < MASTER_NUM; i++) begin : g_pending
    assign req_pending[i] = m_req[i].read | m_req[i].write;
  end

  //////////////////////////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////////////////////////

  avl_bus_arbiter #(
    .MASTER_NUM (MASTER_NUM)
  ) u_arbiter (
    .clk         (clk),
    .arst_n      (arst_n),
    .req_pending (req_pending),
    .unmapped    (unmapped),
    .slave_done  (slave_done),
    .expire      (expire),
    .state       (state),
    .grant       (grant)
  );

  avl_bus_timeout #(
    .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
  ) u_timeout (
    .clk    (clk),
    .arst_n (arst_n),
    .state  (state),
    .expire (expire)
  );

  //////////////////////////////////////////////////////////////////////
  // address map and data
  //////////////////////////////////////////////////////////////////////

  avl_bus_addr_decode #(
    .SLAVE_NUM     (SLAVE_NUM),
    .MAP_BASE      (MAP_BASE),
    .MAP_FIELD_LEN (MAP_FIELD_LEN)
  ) u_addr_decode (
    .addr      (cur_addr),
    .slave_sel (slave_sel),
    .unmapped  (unmapped)
  );

  avl_bus_datapath #(
    .MASTER_NUM (MASTER_NUM),
    .SLAVE_NUM  (SLAVE_NUM)
  ) u_datapath (
    .clk        (clk),
    .arst_n     (arst_n),
    .m_req      (m_req),
    .m_rsp      (m_rsp),
    .s_req      (s_req),
    .s_rsp      (s_rsp),
    .state      (state),
    .grant      (grant),
    .slave_sel  (slave_sel),
    .cur_addr   (cur_addr),
    .slave_done (slave_done)
  );

endmodule

/* dv/avl_bus_n2n_props.sv */
module avl_bus_n2n_props #(
  parameter int MASTER_NUM     = 3,
  parameter int SLAVE_NUM      = 4,
  parameter int TIMEOUT_CYCLES = 16,
  parameter int SILENT_SLAVE   = 3
) (
  input logic                   clk,
  input logic                   arst_n,
  input avl_bus_pkg::avl_req_t  m_req [MASTER_NUM],
  input avl_bus_pkg::avl_mrsp_t m_rsp [MASTER_NUM],
  input avl_bus_pkg::avl_req_t  s_req [SLAVE_NUM]
);

  import avl_bus_pkg::*;

  // upper 16 address bits of each slave window
  localparam logic [15:0] MAP_TOP [4] = '{16'h0000, 16'h0001, 16'h8000, 16'h8001};

  int unsigned                           err_count = 0;  // polled by the testbench
  logic [MASTER_NUM-1:0]                 ack_vec;
  logic [MASTER_NUM-1:0]                 req_vec;
  logic [MASTER_NUM-1:0]                 err_miss;
  logic [MASTER_NUM-1:0]                 twice_vec;
  logic [SLAVE_NUM-1:0]                  stb_vec;
  logic [SLAVE_NUM-1:0]                  stray_vec;
  logic [MASTER_NUM-1:0][MASTER_NUM-1:0] seen;  // seen[k][i] = i acked while k waits
  int unsigned                           silent_age;

  function automatic int owner(addr_t addr);
    int sel;
    sel = SLAVE_NUM;
    for (int j = 0; j < 4; j++) begin
      if (sel == SLAVE_NUM && addr[31:16] == MAP_TOP[j]) begin
        sel = j;
      end
    end
    return sel;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // port observation
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    int   tgt;
    logic hit;
    for (int i = 0; i < MASTER_NUM; i++) begin
      ack_vec[i] = m_rsp[i].ack;
      req_vec[i] = m_req[i].read | m_req[i].write;
      tgt        = owner(m_req[i].addr);
      err_miss[i] = m_rsp[i].ack && ((tgt == SLAVE_NUM && !m_rsp[i].err) ||
                    (tgt == SILENT_SLAVE && (!m_rsp[i].err || m_rsp[i].rdata != '0)));
    end
    for (int k = 0; k < MASTER_NUM; k++) begin
      twice_vec[k] = req_vec[k] && !ack_vec[k] && (|(seen[k] & ack_vec));
    end
    for (int j = 0; j < SLAVE_NUM; j++) begin
      stb_vec[j] = s_req[j].read | s_req[j].write;
      hit        = 1'b0;
      for (int i = 0; i < MASTER_NUM; i++) begin
        if (req_vec[i] && m_req[i] == s_req[j]) begin
          hit = 1'b1;  // strobe is an unchanged copy of a held request
        end
      end
      stray_vec[j] = stb_vec[j] && (!hit || owner(s_req[j].addr) != j);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      seen       <= '0;
      silent_age <= 0;
    end else begin
      for (int k = 0; k < MASTER_NUM; k++) begin
        if (!req_vec[k] || ack_vec[k]) begin
          seen[k] <= '0;
        end else begin
          seen[k] <= seen[k] | ack_vec;
        end
      end
      if (stb_vec[SILENT_SLAVE]) begin
        silent_age <= 1;
      end else if (ack_vec != '0) begin
        silent_age <= 0;
      end else if (silent_age != 0) begin
        silent_age <= silent_age + 1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // properties
  //////////////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk)
    (!arst_n || $past(!arst_n)) |-> (ack_vec == '0 && stb_vec == '0))
    else begin
      err_count++;
      $error("ack or strobe high around reset");
    end

  a_one_strobe: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(stb_vec))
    else begin
      err_count++;
      $error("more than one slave strobe");
    end

  a_one_ack: assert property (@(posedge clk) disable iff (!arst_n) $onehot0(ack_vec))
    else begin
      err_count++;
      $error("more than one master ack");
    end

  a_ack_held: assert property (@(posedge clk) disable iff (!arst_n)
    (ack_vec & ~req_vec) == '0)
    else begin
      err_count++;
      $error("ack to a master without a request");
    end

  a_strobe_route: assert property (@(posedge clk) disable iff (!arst_n) stray_vec == '0)
    else begin
      err_count++;
      $error("strobe at wrong slave or with wrong fields");
    end

  a_error_ack: assert property (@(posedge clk) disable iff (!arst_n) err_miss == '0)
    else begin
      err_count++;
      $error("unmapped or timed out access acked without error");
    end

  a_round_robin: assert property (@(posedge clk) disable iff (!arst_n) twice_vec == '0)
    else begin
      err_count++;
      $error("master served twice while another waited");
    end

  a_no_early_ack: assert property (@(posedge clk) disable iff (!arst_n)
    (silent_age != 0 && silent_age <= TIMEOUT_CYCLES) |-> ack_vec == '0)
    else begin
      err_count++;
      $error("ack before the timeout window closed");
    end

  a_timeout_ack: assert property (@(posedge clk) disable iff (!arst_n)
    (silent_age == TIMEOUT_CYCLES + 1) |-> ack_vec != '0)
    else begin
      err_count++;
      $error("no ack when the timeout expired");
    end

endmodule

bind avl_bus_n2n avl_bus_n2n_props #(
  .MASTER_NUM     (MASTER_NUM),
  .SLAVE_NUM      (SLAVE_NUM),
  .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
) u_props (
  .clk    (clk),
  .arst_n (arst_n),
  .m_req  (m_req),
  .m_rsp  (m_rsp),
  .s_req  (s_req)
);

/* dv/avl_bus_n2n_tb.sv */
module avl_bus_n2n_tb;

  import avl_bus_pkg::*;

  localparam int    MASTER_NUM = 3;
  localparam int    SLAVE_NUM  = 4;
  localparam int    MEM_SLAVES = 3;  // slave 3 never answers
  localparam int    WORDS      = 16;
  localparam int    FIELD_LEN  = 16;
  localparam int    ACK_LIMIT  = 100;
  localparam int    RUN_LIMIT  = 20000;
  localparam int    RANDOM_OPS = 24;
  localparam addr_t UNMAPPED   = 32'h4000_0000;

  localparam addr_t MAP_BASE [SLAVE_NUM] = '{
    32'h0000_0000, 32'h0001_0000, 32'h8000_0000, 32'h8001_0000
  };
  localparam data_t FILL_KEY [MEM_SLAVES] = '{32'h5a5a_0000, 32'h0f0f_1111, 32'hc3c3_2222};

  logic      clk;
  logic      arst_n;
  avl_req_t  m_req [MASTER_NUM];
  avl_mrsp_t m_rsp [MASTER_NUM];
  avl_req_t  s_req [SLAVE_NUM];
  avl_srsp_t s_rsp [SLAVE_NUM];

  data_t slave_mem [MEM_SLAVES][WORDS];  // storage inside the slave models
  data_t exp_mem   [MEM_SLAVES][WORDS];  // what the masters expect back

  avl_bus_n2n uut (
    .clk    (clk),
    .arst_n (arst_n),
    .m_req  (m_req),
    .m_rsp  (m_rsp),
    .s_req  (s_req),
    .s_rsp  (s_rsp)
  );

  always #10 clk = ~clk;

  //////////////////////////////////////////////////////////////////////
  // reference rules
  //////////////////////////////////////////////////////////////////////

  function automatic data_t fill_word(int s, int w);
    return (MAP_BASE[s] | addr_t'(w * 4)) ^ FILL_KEY[s];
  endfunction

  function automatic data_t merge_bytes(data_t old, data_t wdata, be_t be);
    data_t res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  // -1 when no slave claims the address
  function automatic int target_of(addr_t addr);
    int hit;
    hit = -1;
    for (int s = 0; s < SLAVE_NUM; s++) begin
      if (hit < 0 && (addr >> (32 - FIELD_LEN)) == (MAP_BASE[s] >> (32 - FIELD_LEN))) begin
        hit = s;
      end
    end
    return hit;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("=== FAIL ===");
    $fatal(1, "run stopped");
  endtask

  task automatic report_mismatch(input string name, input data_t got, input data_t exp);
    $display("[FAIL] t=%0t %s got %h expected %h", $time, name, got, exp);
    $display("=== FAIL ===");
    $fatal(1, "value mismatch");
  endtask

  //////////////////////////////////////////////////////////////////////
  // masters
  //////////////////////////////////////////////////////////////////////

  // entered right after a rising edge, returns on one
  task automatic access(input int m, input avl_req_t req, output avl_mrsp_t rsp);
    int waited;
    m_req[m] <= req;
    waited = 0;
    do begin
      @(negedge clk);
      waited++;
      if (waited > ACK_LIMIT) begin
        report_failure($sformatf("master %0d got no ack within %0d cycles", m, ACK_LIMIT));
      end
    end while (!m_rsp[m].ack);
    rsp = m_rsp[m];
    @(posedge clk);
    m_req[m] <= '0;  // a following access overrides this
  endtask

  task automatic transact(input int m, input bit wr, input addr_t addr, input data_t wdata,
                          input be_t be);
    avl_req_t  req;
    avl_mrsp_t rsp;
    int        s;
    int        w;
    req            = '0;
    req.read       = !wr;
    req.write      = wr;
    req.addr       = addr;
    req.wdata      = wdata;
    req.byteenable = be;
    access(m, req, rsp);
    s = target_of(addr);
    w = int'(addr[5:2]);
    if (s >= 0 && s < MEM_SLAVES) begin
      assert (rsp.err == 1'b0)
        else report_mismatch($sformatf("m_rsp[%0d].err", m), rsp.err, 0);
      if (wr) begin
        exp_mem[s][w] = merge_bytes(exp_mem[s][w], wdata, be);
      end
      assert (rsp.rdata == (wr ? '0 : exp_mem[s][w]))
        else report_mismatch($sformatf("m_rsp[%0d].rdata", m), rsp.rdata,
                             wr ? '0 : exp_mem[s][w]);
    end else begin
      assert (rsp.err == 1'b1)
        else report_mismatch($sformatf("m_rsp[%0d].err", m), rsp.err, 1);
      if (s >= 0) begin
        assert (rsp.rdata == '0)
          else report_mismatch($sformatf("m_rsp[%0d].rdata", m), rsp.rdata, 0);
      end
    end
  endtask

  task automatic master_traffic(input int m);
    addr_t addr;
    int    w;
    int    kind;
    // back to back, so all masters contend during this part
    for (int s = 0; s < MEM_SLAVES; s++) begin
      w = m * 4 + s;
      transact(m, 1'b1, MAP_BASE[s] | addr_t'(w * 4), $urandom, 4'hf);
      transact(m, 1'b0, MAP_BASE[s] | addr_t'(w * 4), '0, 4'hf);
    end
    transact(m, 1'b0, UNMAPPED, '0, 4'hf);
    transact(m, 1'b1, MAP_BASE[3] | addr_t'(m * 4), $urandom, 4'hf);
    for (int n = 0; n < RANDOM_OPS; n++) begin
      kind = int'($urandom % 10);
      w    = m * 4 + int'($urandom % 4);  // each master owns four words per slave
      if (kind == 0) begin
        addr = UNMAPPED | addr_t'(w * 4);
      end else if (kind == 1) begin
        addr = MAP_BASE[3] | addr_t'(w * 4);
      end else begin
        addr = MAP_BASE[kind % MEM_SLAVES] | addr_t'(w * 4);
      end
      transact(m, ($urandom % 2) == 1, addr, $urandom, be_t'($urandom));
      repeat ($urandom % 3) @(posedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // slave models
  //////////////////////////////////////////////////////////////////////

  task automatic slave_model(input int s);
    avl_req_t  req;
    avl_srsp_t rsp;
    int        w;
    int        delay;
    forever begin
      @(negedge clk);
      if (s_req[s].read || s_req[s].write) begin
        req   = s_req[s];
        w     = int'(req.addr[5:2]);
        delay = 1 + int'($urandom % 6);
        if (req.write) begin
          slave_mem[s][w] = merge_bytes(slave_mem[s][w], req.wdata, req.byteenable);
        end
        rsp.done  = 1'b1;
        rsp.rdata = req.read ? slave_mem[s][w] : '0;
        repeat (delay) @(posedge clk);
        s_rsp[s] <= rsp;
        @(posedge clk);
        s_rsp[s] <= '0;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (uut.u_props.err_count != 0) begin
      report_failure("an interconnect property failed, see the error above");
    end
  end

  initial begin
    repeat (RUN_LIMIT) @(posedge clk);
    report_failure("run did not finish within the cycle limit");
  end

  initial begin
    void'($urandom(15506));
    clk    = 1'b0;
    arst_n = 1'b0;
    for (int i = 0; i < MASTER_NUM; i++) begin
      m_req[i] = '0;
    end
    for (int j = 0; j < SLAVE_NUM; j++) begin
      s_rsp[j] = '0;
    end
    for (int s = 0; s < MEM_SLAVES; s++) begin
      for (int w = 0; w < WORDS; w++) begin
        slave_mem[s][w] = fill_word(s, w);
        exp_mem[s][w]   = fill_word(s, w);
      end
    end
    repeat (8) @(posedge clk);
    arst_n <= 1'b1;
    @(posedge clk);
    fork
      slave_model(0);
      slave_model(1);
      slave_model(2);
    join_none
    fork
      master_traffic(0);
      master_traffic(1);
      master_traffic(2);
    join
    repeat (4) @(posedge clk);
    if (uut.u_props.err_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_failure("an interconnect property failed during the run");
    end
  end

endmodule

/* build.f */
hw/avl_bus_pkg.sv
hw/avl_bus_arbiter.sv
hw/avl_bus_timeout.sv
hw/avl_bus_addr_decode.sv
hw/avl_bus_datapath.sv
hw/avl_bus_n2n.sv
dv/avl_bus_n2n_props.sv
dv/avl_bus_n2n_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module avl_bus_n2n_tb \
  -f build.f \
  -o avl_bus_n2n_sim

# the raised error limit lets the testbench end a run after a property failure
./obj_dir/avl_bus_n2n_sim +verilator+error+limit+100 | tee sim.log

if grep -q "=== PASS ===" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
